//--- hdl/fu_settings.svh
`ifndef FU_SETTINGS_SVH
`define FU_SETTINGS_SVH

// Machine word width in bits
`define FU_XLEN 64

// Reorder buffer entries, power of two so tag arithmetic wraps
`define FU_NUM_ROB 32

// Physical register file size
`define FU_NUM_PR 64

// Multiplier pipeline depth
// Must divide FU_XLEN evenly, each stage folds XLEN/STAGES bits
`define FU_MULT_STAGES 4

`endif

//--- hdl/fu_tag_pkg.sv
`default_nettype none

`include "fu_settings.svh"

package fu_tag_pkg;

  localparam int ROB_W  = $clog2(`FU_NUM_ROB);
  localparam int PREG_W = $clog2(`FU_NUM_PR);

  typedef logic [`FU_XLEN-1:0] data_t;
  typedef logic [ROB_W-1:0]    rob_idx_t;
  typedef logic [PREG_W-1:0]   preg_idx_t;
  typedef logic [31:0]         inst_t;

  // True when the entry lies strictly younger than the rollback point
  // and no further than the span. Age wraps with the ROB size.
  function automatic logic rob_squashed(
    input rob_idx_t rob,
    input logic     rollback_en,
    input rob_idx_t rollback_rob,
    input rob_idx_t rollback_span
  );
    rob_idx_t age;
    age = rob - rollback_rob;
    return rollback_en && (age <= rollback_span) && (age != '0);
  endfunction

endpackage

`default_nettype wire

//--- hdl/fu_op_pkg.sv
`default_nettype none

package fu_op_pkg;

  typedef enum logic [3:0] {
    ALU_ADDQ,
    ALU_SUBQ,
    ALU_AND,
    ALU_BIC,    // a & ~b
    ALU_BIS,    // a | b
    ALU_ORNOT,
    ALU_XOR,
    ALU_EQV,    // a ^ ~b
    ALU_SRL,
    ALU_SLL,
    ALU_SRA,
    ALU_CMPULT,
    ALU_CMPEQ,
    ALU_CMPULE,
    ALU_CMPLT,
    ALU_CMPLE
  } alu_func_e;

  typedef enum logic {
    OPA_IS_RS1,
    OPA_IS_MEM_DISP
  } opa_sel_e;

  typedef enum logic {
    OPB_IS_RS2,
    OPB_IS_LIT
  } opb_sel_e;

  // Operate-format literal, zero extended
  localparam int LIT_LSB = 13;
  localparam int LIT_MSB = 20;

  // Memory displacement occupies inst[DISP_MSB:0], sign extended
  localparam int DISP_MSB = 15;

endpackage

`default_nettype wire

//--- hdl/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "fu_settings.svh"

module alu_unit
  import fu_tag_pkg::*;
  import fu_op_pkg::*;
(
  input  logic      rollback_en,
  input  rob_idx_t  rollback_rob,
  input  rob_idx_t  rollback_span,
  input  logic      issue,
  input  alu_func_e func,
  input  opa_sel_e  opa_sel,
  input  opb_sel_e  opb_sel,
  input  inst_t     inst,
  input  data_t     rs1,
  input  data_t     rs2,
  input  rob_idx_t  rob,
  input  preg_idx_t preg,
  input  logic      grant,
  output logic      free,
  output logic      done,
  output data_t     result,
  output rob_idx_t  rob_out,
  output preg_idx_t preg_out
);

  localparam int SHAMT_W = $clog2(`FU_XLEN);
  localparam int LIT_W   = LIT_MSB - LIT_LSB + 1;

  data_t              opa;
  data_t              opb;
  logic [SHAMT_W-1:0] shamt;
  logic               squashed;
  logic               lt;

  // Sign bits decide when they differ, otherwise unsigned compare is exact
  function automatic logic signed_lt(input data_t a, input data_t b);
    if (a[`FU_XLEN-1] == b[`FU_XLEN-1]) begin
      return a < b;
    end
    return a[`FU_XLEN-1];
  endfunction

  always_comb begin
    case (opa_sel)
      OPA_IS_MEM_DISP: opa = {{(`FU_XLEN-DISP_MSB-1){inst[DISP_MSB]}}, inst[DISP_MSB:0]};
      default:         opa = rs1;
    endcase
  end

  always_comb begin
    case (opb_sel)
      OPB_IS_LIT: opb = {{(`FU_XLEN-LIT_W){1'b0}}, inst[LIT_MSB:LIT_LSB]};
      default:    opb = rs2;
    endcase
  end

  assign shamt = opb[SHAMT_W-1:0];
  assign lt    = signed_lt(opa, opb);

  always_comb begin
    case (func)
      ALU_ADDQ:   result = opa + opb;
      ALU_SUBQ:   result = opa - opb;
      ALU_AND:    result = opa & opb;
      ALU_BIC:    result = opa & ~opb;
      ALU_BIS:    result = opa | opb;
      ALU_ORNOT:  result = opa | ~opb;
      ALU_XOR:    result = opa ^ opb;
      ALU_EQV:    result = opa ^ ~opb;
      ALU_SRL:    result = opa >> shamt;
      ALU_SLL:    result = opa << shamt;
      ALU_SRA:    result = data_t'($signed(opa) >>> shamt);
      ALU_CMPULT: result = data_t'(opa < opb);
      ALU_CMPEQ:  result = data_t'(opa == opb);
      ALU_CMPULE: result = data_t'(opa <= opb);
      ALU_CMPLT:  result = data_t'(lt);
      ALU_CMPLE:  result = data_t'(lt || (opa == opb));
      default:    result = '0;
    endcase
  end

  assign squashed = rob_squashed(rob, rollback_en, rollback_rob, rollback_span);

  // Single cycle, so the unit frees as soon as the result is taken
  assign done     = issue && !squashed;
  assign free     = grant || !issue || squashed;
  assign rob_out  = rob;
  assign preg_out = preg;

endmodule

`default_nettype wire

//--- hdl/mult_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "fu_settings.svh"

module mult_stage
  import fu_tag_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      advance,
  input  logic      in_valid,
  input  data_t     product_in,
  input  data_t     mplier_in,
  input  data_t     mcand_in,
  input  rob_idx_t  rob_in,
  input  preg_idx_t preg_in,
  input  logic      rollback_en,
  input  rob_idx_t  rollback_rob,
  input  rob_idx_t  rollback_span,
  output logic      out_valid,
  output data_t     product_out,
  output data_t     mplier_out,
  output data_t     mcand_out,
  output rob_idx_t  rob_out,
  output preg_idx_t preg_out
);

  localparam int SLICE = `FU_XLEN / `FU_MULT_STAGES;

  data_t partial;
  logic  squash_in;
  logic  squash_held;

  // Low slice of the multiplier against the whole multiplicand
  assign partial = data_t'(mplier_in[SLICE-1:0]) * mcand_in;

  assign squash_in   = rob_squashed(rob_in, rollback_en, rollback_rob, rollback_span);
  assign squash_held = rob_squashed(rob_out, rollback_en, rollback_rob, rollback_span);

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (advance) begin
      out_valid <= in_valid && !squash_in;
    end else if (squash_held) begin
      out_valid <= 1'b0; // Stalled entry killed in place
    end
  end

  always_ff @(posedge clock) begin
    if (advance) begin
      product_out <= product_in + partial;
      mplier_out  <= mplier_in >> SLICE;
      mcand_out   <= mcand_in << SLICE;
      rob_out     <= rob_in;
      preg_out    <= preg_in;
    end
  end

endmodule

`default_nettype wire

//--- hdl/mult_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "fu_settings.svh"

module mult_unit
  import fu_tag_pkg::*;
  import fu_op_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      en,
  input  logic      rollback_en,
  input  rob_idx_t  rollback_rob,
  input  rob_idx_t  rollback_span,
  input  logic      issue,
  input  opb_sel_e  opb_sel,
  input  inst_t     inst,
  input  data_t     rs1,
  input  data_t     rs2,
  input  rob_idx_t  rob,
  input  preg_idx_t preg,
  input  logic      grant,
  output logic      free,
  output logic      done,
  output data_t     result,
  output rob_idx_t  rob_out,
  output preg_idx_t preg_out
);

  localparam int N     = `FU_MULT_STAGES;
  localparam int LIT_W = LIT_MSB - LIT_LSB + 1;

  // Index 0 is the issue side, index N the last stage
  logic      [N:0] chain_valid;
  data_t     [N:0] chain_product;
  data_t     [N:0] chain_mplier;
  data_t     [N:0] chain_mcand;
  rob_idx_t  [N:0] chain_rob;
  preg_idx_t [N:0] chain_preg;
  logic            advance;

  assign chain_valid[0]   = issue;
  assign chain_product[0] = '0;
  assign chain_mplier[0]  = rs1;
  assign chain_mcand[0]   = (opb_sel == OPB_IS_LIT) ?
                            {{(`FU_XLEN-LIT_W){1'b0}}, inst[LIT_MSB:LIT_LSB]} : rs2;
  assign chain_rob[0]     = rob;
  assign chain_preg[0]    = preg;

  // Squashed tail entry drops off the bus right away
  assign done    = chain_valid[N] &&
                   !rob_squashed(chain_rob[N], rollback_en, rollback_rob, rollback_span);
  assign advance = en && (grant || !done);
  assign free    = advance;

  for (genvar i = 0; i < N; i++) begin : g_stage
    mult_stage stage_i (
      .clock(clock), .reset(reset), .advance(advance),
      .in_valid(chain_valid[i]), .product_in(chain_product[i]),
      .mplier_in(chain_mplier[i]), .mcand_in(chain_mcand[i]),
      .rob_in(chain_rob[i]), .preg_in(chain_preg[i]),
      .rollback_en(rollback_en), .rollback_rob(rollback_rob),
      .rollback_span(rollback_span),
      .out_valid(chain_valid[i+1]), .product_out(chain_product[i+1]),
      .mplier_out(chain_mplier[i+1]), .mcand_out(chain_mcand[i+1]),
      .rob_out(chain_rob[i+1]), .preg_out(chain_preg[i+1])
    );
  end

  assign result   = chain_product[N];
  assign rob_out  = chain_rob[N];
  assign preg_out = chain_preg[N];

endmodule

`default_nettype wire

//--- hdl/fu_top.sv
`timescale 1ns/1ps
`default_nettype none

module fu_top
  import fu_tag_pkg::*;
  import fu_op_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      en,
  input  logic      rollback_en,
  input  rob_idx_t  rollback_rob,
  input  rob_idx_t  rollback_span,
  // ALU side
  input  logic      alu_issue,
  input  alu_func_e alu_func,
  input  opa_sel_e  alu_opa_sel,
  input  opb_sel_e  alu_opb_sel,
  input  inst_t     alu_inst,
  input  data_t     alu_rs1,
  input  data_t     alu_rs2,
  input  rob_idx_t  alu_rob,
  input  preg_idx_t alu_preg,
  input  logic      alu_grant,
  output logic      alu_free,
  output logic      alu_done,
  output data_t     alu_result,
  output rob_idx_t  alu_rob_out,
  output preg_idx_t alu_preg_out,
  // Multiplier side
  input  logic      mult_issue,
  input  opb_sel_e  mult_opb_sel,
  input  inst_t     mult_inst,
  input  data_t     mult_rs1,
  input  data_t     mult_rs2,
  input  rob_idx_t  mult_rob,
  input  preg_idx_t mult_preg,
  input  logic      mult_grant,
  output logic      mult_free,
  output logic      mult_done,
  output data_t     mult_result,
  output rob_idx_t  mult_rob_out,
  output preg_idx_t mult_preg_out
);

  alu_unit alu_unit_i (
    .rollback_en(rollback_en), .rollback_rob(rollback_rob), .rollback_span(rollback_span),
    .issue(alu_issue), .func(alu_func), .opa_sel(alu_opa_sel), .opb_sel(alu_opb_sel),
    .inst(alu_inst), .rs1(alu_rs1), .rs2(alu_rs2), .rob(alu_rob), .preg(alu_preg),
    .grant(alu_grant), .free(alu_free), .done(alu_done), .result(alu_result),
    .rob_out(alu_rob_out), .preg_out(alu_preg_out)
  );

  mult_unit mult_unit_i (
    .clock(clock), .reset(reset), .en(en),
    .rollback_en(rollback_en), .rollback_rob(rollback_rob), .rollback_span(rollback_span),
    .issue(mult_issue), .opb_sel(mult_opb_sel), .inst(mult_inst),
    .rs1(mult_rs1), .rs2(mult_rs2), .rob(mult_rob), .preg(mult_preg),
    .grant(mult_grant), .free(mult_free), .done(mult_done), .result(mult_result),
    .rob_out(mult_rob_out), .preg_out(mult_preg_out)
  );

endmodule

`default_nettype wire

//--- dv/fu_properties.sv
`timescale 1ns/1ps
`default_nettype none

module fu_properties
  import fu_tag_pkg::*;
(
  input logic      clock,
  input logic      reset,
  input logic      en,
  input logic      rollback_en,
  input logic      alu_issue,
  input logic      alu_free,
  input logic      alu_done,
  input logic      mult_grant,
  input logic      mult_free,
  input logic      mult_done,
  input data_t     mult_result,
  input rob_idx_t  mult_rob_out,
  input preg_idx_t mult_preg_out
);

  int unsigned fail_count = 0;

  // Pipeline comes out of reset empty and ready
  reset_empty: assert property (@(posedge clock) reset |=> !mult_done)
    else begin
      fail_count++;
      $error("mult_done high right after reset");
    end

  reset_ready: assert property (@(posedge clock) $fell(reset) && en |-> mult_free)
    else begin
      fail_count++;
      $error("mult_free low in the first cycle after reset");
    end

  stall_blocks_issue: assert property (@(posedge clock) disable iff (reset)
      mult_done && !mult_grant |-> !mult_free)
    else begin
      fail_count++;
      $error("mult_free high while a result waits for its grant");
    end

  // Waiting result stays put, only a rollback may drop it
  stall_holds_result: assert property (@(posedge clock) disable iff (reset)
      mult_done && !mult_grant |=> $stable(mult_result) && $stable(mult_rob_out) &&
      $stable(mult_preg_out) && (mult_done || rollback_en))
    else begin
      fail_count++;
      $error("result or tags changed while waiting for the grant");
    end

  idle_accepts: assert property (@(posedge clock) disable iff (reset)
      !mult_done && en |-> mult_free)
    else begin
      fail_count++;
      $error("mult_free low with no result waiting");
    end

  alu_needs_issue: assert property (@(posedge clock) !alu_issue |-> alu_free && !alu_done)
    else begin
      fail_count++;
      $error("ALU busy or done without an issue");
    end

endmodule

bind fu_top fu_properties fu_properties_i (
  .clock(clock), .reset(reset), .en(en), .rollback_en(rollback_en),
  .alu_issue(alu_issue), .alu_free(alu_free), .alu_done(alu_done),
  .mult_grant(mult_grant), .mult_free(mult_free), .mult_done(mult_done),
  .mult_result(mult_result), .mult_rob_out(mult_rob_out), .mult_preg_out(mult_preg_out)
);

`default_nettype wire

//--- dv/fu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fu_settings.svh"

module fu_tb
  import fu_tag_pkg::*;
  import fu_op_pkg::*;
();

  localparam int PERIOD         = 100;
  localparam int BURST          = 12;
  localparam int RANDOM_CYCLES  = 640;
  localparam int NUM_ISSUES     = BURST + RANDOM_CYCLES;
  localparam int TIMEOUT_CYCLES = NUM_ISSUES * 8 + 100;

  typedef struct packed {
    data_t      product;
    rob_idx_t   rob;
    preg_idx_t  preg;
    logic       squashed;
    logic [2:0] age;      // Advancing edges since accepted
  } mult_entry_t;

  logic      clock = 1'b0;
  logic      reset;
  logic      en;
  logic      rollback_en;
  rob_idx_t  rollback_rob;
  rob_idx_t  rollback_span;
  logic      alu_issue;
  alu_func_e alu_func;
  opa_sel_e  alu_opa_sel;
  opb_sel_e  alu_opb_sel;
  inst_t     alu_inst;
  data_t     alu_rs1;
  data_t     alu_rs2;
  rob_idx_t  alu_rob;
  preg_idx_t alu_preg;
  logic      alu_grant;
  logic      alu_free;
  logic      alu_done;
  data_t     alu_result;
  rob_idx_t  alu_rob_out;
  preg_idx_t alu_preg_out;
  logic      mult_issue;
  opb_sel_e  mult_opb_sel;
  inst_t     mult_inst;
  data_t     mult_rs1;
  data_t     mult_rs2;
  rob_idx_t  mult_rob;
  preg_idx_t mult_preg;
  logic      mult_grant;
  logic      mult_free;
  logic      mult_done;
  data_t     mult_result;
  rob_idx_t  mult_rob_out;
  preg_idx_t mult_preg_out;

  mult_entry_t pending[$];
  logic        exp_alu_done;
  logic        exp_alu_free;
  data_t       exp_alu_result;
  logic        exp_mult_done;
  logic        exp_mult_free;
  data_t       exp_mult_result;
  rob_idx_t    exp_mult_rob;
  preg_idx_t   exp_mult_preg;
  logic        alu_hold;
  logic        mult_hold;
  int          alu_errors = 0;
  int          mult_errors = 0;
  int          total_errors;

  fu_top fu_top_i (.*);

  always #(PERIOD / 2) clock = ~clock;

  function automatic data_t lit_operand(input inst_t inst);
    return data_t'(inst[LIT_MSB:LIT_LSB]);
  endfunction

  task automatic report_mismatch(input string name, input data_t expected,
                                 input data_t actual, input bit on_mult);
    if (on_mult) begin
      mult_errors++;
    end else begin
      alu_errors++;
    end
    $display("[ERROR] %s: expected %h, actual %h at %0t", name, expected, actual, $time);
  endtask

  task automatic predict_alu(output data_t res);
    data_t      a;
    data_t      b;
    logic [5:0] sh;
    a  = (alu_opa_sel == OPA_IS_MEM_DISP) ? data_t'($signed(alu_inst[DISP_MSB:0])) : alu_rs1;
    b  = (alu_opb_sel == OPB_IS_LIT) ? lit_operand(alu_inst) : alu_rs2;
    sh = b[5:0];
    case (alu_func)
      ALU_ADDQ:   res = a + b;
      ALU_SUBQ:   res = a - b;
      ALU_AND:    res = a & b;
      ALU_BIC:    res = a & ~b;
      ALU_BIS:    res = a | b;
      ALU_ORNOT:  res = a | ~b;
      ALU_XOR:    res = a ^ b;
      ALU_EQV:    res = ~(a ^ b);
      ALU_SRL:    res = a >> sh;
      ALU_SLL:    res = a << sh;
      ALU_SRA:    res = data_t'($signed(a) >>> sh);
      ALU_CMPULT: res = data_t'(a < b);
      ALU_CMPEQ:  res = data_t'(a == b);
      ALU_CMPULE: res = data_t'(a <= b);
      ALU_CMPLT:  res = data_t'($signed(a) < $signed(b));
      ALU_CMPLE:  res = data_t'($signed(a) <= $signed(b));
      default:    res = '0;
    endcase
  endtask

  // Applies the edge that just passed to the expected multiplier queue
  task automatic update_model();
    logic        adv;
    mult_entry_t e;
    adv       = en && (mult_grant || !exp_mult_done);
    alu_hold  = alu_issue && !exp_alu_free;
    mult_hold = mult_issue && !adv;
    if (reset) begin
      pending.delete();
    end else begin
      foreach (pending[i]) begin
        e = pending[i];
        if (rob_squashed(e.rob, rollback_en, rollback_rob, rollback_span)) begin
          e.squashed = 1'b1;
          pending[i] = e;
        end
      end
      if (adv) begin
        if (pending.size() > 0 && pending[0].age == 3'(`FU_MULT_STAGES)) begin
          void'(pending.pop_front());
        end
        foreach (pending[i]) begin
          e = pending[i];
          e.age = e.age + 3'd1;
          pending[i] = e;
        end
        if (mult_issue) begin
          e.product  = mult_rs1 * ((mult_opb_sel == OPB_IS_LIT) ?
                                   lit_operand(mult_inst) : mult_rs2);
          e.rob      = mult_rob;
          e.preg     = mult_preg;
          e.squashed = rob_squashed(mult_rob, rollback_en, rollback_rob, rollback_span);
          e.age      = 3'd1;
          pending.push_back(e);
        end
      end
    end
  endtask

  task automatic compute_expected();
    logic alu_squash;
    alu_squash   = rob_squashed(alu_rob, rollback_en, rollback_rob, rollback_span);
    exp_alu_done = alu_issue && !alu_squash;
    exp_alu_free = alu_grant || !alu_issue || alu_squash;
    predict_alu(exp_alu_result);
    exp_mult_done   = 1'b0;
    exp_mult_result = '0;
    exp_mult_rob    = '0;
    exp_mult_preg   = '0;
    if (pending.size() > 0 && pending[0].age == 3'(`FU_MULT_STAGES)) begin
      exp_mult_done   = !pending[0].squashed &&
                        !rob_squashed(pending[0].rob, rollback_en, rollback_rob, rollback_span);
      exp_mult_result = pending[0].product;
      exp_mult_rob    = pending[0].rob;
      exp_mult_preg   = pending[0].preg;
    end
    exp_mult_free = en && (mult_grant || !exp_mult_done);
  endtask

  task automatic drive_inputs(input int n, input bit burst);
    if (!alu_hold) begin
      alu_issue   = ($urandom % 8) != 0;
      alu_func    = alu_func_e'(4'(n));   // Sweeps all functions and selects
      alu_opa_sel = opa_sel_e'(1'(n >> 4));
      alu_opb_sel = opb_sel_e'(1'(n >> 5));
      alu_inst    = $urandom;
      alu_rs1     = {$urandom, $urandom};
      alu_rs2     = ($urandom % 4 == 0) ? alu_rs1 : {$urandom, $urandom};
      alu_rob     = rob_idx_t'($urandom);
      alu_preg    = preg_idx_t'($urandom);
    end
    alu_grant = ($urandom % 4) != 0;
    if (!mult_hold) begin
      mult_issue   = burst || (($urandom % 3) != 0);
      mult_opb_sel = opb_sel_e'(1'($urandom));
      mult_inst    = $urandom;
      mult_rs1     = {$urandom, $urandom};
      mult_rs2     = {$urandom, $urandom};
      mult_rob     = rob_idx_t'($urandom);
      mult_preg    = preg_idx_t'($urandom);
    end
    mult_grant    = burst || (($urandom % 4) != 0);
    en            = burst || (($urandom % 16) != 0);
    rollback_en   = !burst && (($urandom % 6) == 0);
    rollback_rob  = mult_rob - rob_idx_t'($urandom % 3); // Near the newest entries
    rollback_span = rob_idx_t'($urandom % 8);
  endtask

  task automatic step(input int n, input bit burst);
    @(negedge clock);
    update_model();
    drive_inputs(n, burst);
    compute_expected();
  endtask

  alu_done_check: assert property (@(posedge clock) disable iff (reset)
      alu_done == exp_alu_done)
    else report_mismatch("alu_done", data_t'($sampled(exp_alu_done)),
                         data_t'($sampled(alu_done)), 1'b0);

  alu_free_check: assert property (@(posedge clock) disable iff (reset)
      alu_free == exp_alu_free)
    else report_mismatch("alu_free", data_t'($sampled(exp_alu_free)),
                         data_t'($sampled(alu_free)), 1'b0);

  alu_result_check: assert property (@(posedge clock) disable iff (reset)
      exp_alu_done |-> alu_result == exp_alu_result)
    else report_mismatch("alu_result", $sampled(exp_alu_result), $sampled(alu_result), 1'b0);

  alu_tag_check: assert property (@(posedge clock) disable iff (reset)
      exp_alu_done |-> {alu_rob_out, alu_preg_out} == {alu_rob, alu_preg})
    else report_mismatch("alu_tags", data_t'($sampled({alu_rob, alu_preg})),
                         data_t'($sampled({alu_rob_out, alu_preg_out})), 1'b0);

  mult_done_check: assert property (@(posedge clock) disable iff (reset)
      mult_done == exp_mult_done)
    else report_mismatch("mult_done", data_t'($sampled(exp_mult_done)),
                         data_t'($sampled(mult_done)), 1'b1);

  mult_free_check: assert property (@(posedge clock) disable iff (reset)
      mult_free == exp_mult_free)
    else report_mismatch("mult_free", data_t'($sampled(exp_mult_free)),
                         data_t'($sampled(mult_free)), 1'b1);

  mult_result_check: assert property (@(posedge clock) disable iff (reset)
      exp_mult_done |-> mult_result == exp_mult_result)
    else report_mismatch("mult_result", $sampled(exp_mult_result), $sampled(mult_result), 1'b1);

  mult_tag_check: assert property (@(posedge clock) disable iff (reset)
      exp_mult_done |-> {mult_rob_out, mult_preg_out} == {exp_mult_rob, exp_mult_preg})
    else report_mismatch("mult_tags", data_t'($sampled({exp_mult_rob, exp_mult_preg})),
                         data_t'($sampled({mult_rob_out, mult_preg_out})), 1'b1);

  initial begin
    void'($urandom(82303));
    reset         = 1'b1;
    en            = 1'b1;
    rollback_en   = 1'b0;
    rollback_rob  = '0;
    rollback_span = '0;
    alu_issue     = 1'b0;
    alu_func      = ALU_ADDQ;
    alu_opa_sel   = OPA_IS_RS1;
    alu_opb_sel   = OPB_IS_RS2;
    alu_inst      = '0;
    alu_rs1       = '0;
    alu_rs2       = '0;
    alu_rob       = '0;
    alu_preg      = '0;
    alu_grant     = 1'b0;
    mult_issue    = 1'b0;
    mult_opb_sel  = OPB_IS_RS2;
    mult_inst     = '0;
    mult_rs1      = '0;
    mult_rs2      = '0;
    mult_rob      = '0;
    mult_preg     = '0;
    mult_grant    = 1'b0;
    alu_hold      = 1'b0;
    mult_hold     = 1'b0;
    compute_expected();
    repeat (5) @(posedge clock);
    @(negedge clock);
    update_model();
    reset = 1'b0;
    compute_expected();
    // Back to back with the grant held, fills all four stages
    for (int n = 0; n < BURST; n++) begin
      step(n, 1'b1);
    end
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      step(n, 1'b0);
    end
    while (pending.size() > 0) begin
      @(negedge clock);
      update_model();
      alu_issue   = 1'b0;
      mult_issue  = 1'b0;
      mult_grant  = 1'b1;
      en          = 1'b1;
      rollback_en = 1'b0;
      compute_expected();
    end
    repeat (2) @(negedge clock);
    total_errors = alu_errors + mult_errors + int'(fu_top_i.fu_properties_i.fail_count);
    $display("Errors: alu %0d, mult %0d, protocol %0d", alu_errors, mult_errors,
             fu_top_i.fu_properties_i.fail_count);
    if (total_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * PERIOD);
    $display("Watchdog expired after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+hdl
hdl/fu_tag_pkg.sv
hdl/fu_op_pkg.sv
hdl/alu_unit.sv
hdl/mult_stage.sv
hdl/mult_unit.sv
hdl/fu_top.sv
dv/fu_properties.sv
dv/fu_tb.sv

//--- Makefile
TOP = fu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o V$(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir
